/* hw/pixel_pkg.sv */
package pixel_pkg;

    // ********************
    // colour and mode widths
    // ********************
    localparam int CHAN_W = 8;
    localparam int MODE_W = 2;

    // code 3 of the mixer source select is reserved.
    localparam logic [MODE_W-1:0] MODE_CAM1 = 2'd0;
    localparam logic [MODE_W-1:0] MODE_CAM2 = 2'd1;
    localparam logic [MODE_W-1:0] MODE_AVG  = 2'd2;

    // ********************
    // one rgb565 word seen as bytes or as fields
    // ********************
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } pix_bytes_t;

    typedef struct packed {
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
    } pix_fields_t;

    typedef union packed {
        pix_bytes_t  bytes;
        pix_fields_t fields;
    } pix_word_u;

endpackage

/* hw/view_regs_pkg.sv */
package view_regs_pkg;

    // ********************
    // apb port widths
    // ********************
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    // width of the shown and dropped counters.
    localparam int CNT_W = 16;

    // ********************
    // register map
    // ********************
    localparam logic [APB_AW-1:0] ADDR_CTRL  = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_SHOWN = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_DROP  = 4'h8;

    // ctrl layout.
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_MODE_LSB = 1;

endpackage

/* hw/cam_pixel_unpack.sv */
module cam_pixel_unpack (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         vsync,
    input  logic                         href,
    input  logic                         byte_en,
    input  logic [7:0]                   data,
    output logic                         pix_valid,
    output logic [pixel_pkg::CHAN_W-1:0] pix_r,
    output logic [pixel_pkg::CHAN_W-1:0] pix_g,
    output logic [pixel_pkg::CHAN_W-1:0] pix_b
);
    import pixel_pkg::*;

    logic      phase;
    logic      take;
    logic      pair_done;
    pix_word_u word_q;
    pix_word_u word_d;

    // a byte counts only inside a line and outside frame sync.
    assign take      = byte_en && href && !vsync;
    assign pair_done = take && phase;

    // incoming byte merged into the held word.
    always_comb begin
        word_d = word_q;
        if (take) begin
            if (phase) begin
                word_d.bytes.lo = data;
            end else begin
                word_d.bytes.hi = data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= pair_done;
            if (!href || vsync) begin
                phase <= 1'b0;
            end else if (take) begin
                phase <= ~phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        word_q <= word_d;
        if (pair_done) begin
            pix_r <= {word_d.fields.r5, 3'b000};
            pix_g <= {word_d.fields.g6, 2'b00};
            pix_b <= {word_d.fields.b5, 3'b000};
        end
    end

    // pairs need two accepted bytes, so pulses never touch.
    a_valid_single : assert property (
        @(posedge clk) disable iff (!rst_n) pix_valid |=> !pix_valid
    );

endmodule

/* hw/view_mixer.sv */
module view_mixer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  logic [pixel_pkg::MODE_W-1:0] mode,
    input  logic                         a_valid,
    input  logic [pixel_pkg::CHAN_W-1:0] a_r,
    input  logic [pixel_pkg::CHAN_W-1:0] a_g,
    input  logic [pixel_pkg::CHAN_W-1:0] a_b,
    input  logic                         b_valid,
    input  logic [pixel_pkg::CHAN_W-1:0] b_r,
    input  logic [pixel_pkg::CHAN_W-1:0] b_g,
    input  logic [pixel_pkg::CHAN_W-1:0] b_b,
    output logic                         disp_valid,
    output logic [pixel_pkg::CHAN_W-1:0] disp_r,
    output logic [pixel_pkg::CHAN_W-1:0] disp_g,
    output logic [pixel_pkg::CHAN_W-1:0] disp_b,
    output logic                         drop
);
    import pixel_pkg::*;

    logic              a_full;
    logic              b_full;
    logic              a_have;
    logic              b_have;
    logic              avg_on;
    logic              fire;
    logic [CHAN_W-1:0] a_hold_r, a_hold_g, a_hold_b;
    logic [CHAN_W-1:0] b_hold_r, b_hold_g, b_hold_b;
    logic [CHAN_W-1:0] a_eff_r, a_eff_g, a_eff_b;
    logic [CHAN_W-1:0] b_eff_r, b_eff_g, b_eff_b;

    function automatic logic [CHAN_W-1:0] avg2(input logic [CHAN_W-1:0] x,
                                               input logic [CHAN_W-1:0] y);
        logic [CHAN_W:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        return sum[CHAN_W:1];
    endfunction

    // ********************
    // average mode holds
    // ********************
    // a fresh pixel wins over the one in its hold.
    assign a_eff_r = a_valid ? a_r : a_hold_r;
    assign a_eff_g = a_valid ? a_g : a_hold_g;
    assign a_eff_b = a_valid ? a_b : a_hold_b;
    assign b_eff_r = b_valid ? b_r : b_hold_r;
    assign b_eff_g = b_valid ? b_g : b_hold_g;
    assign b_eff_b = b_valid ? b_b : b_hold_b;

    assign a_have = a_valid || a_full;
    assign b_have = b_valid || b_full;
    assign avg_on = enable && (mode == MODE_AVG);

    always_comb begin
        fire = 1'b0;
        if (enable) begin
            case (mode)
                MODE_CAM1: fire = a_valid;
                MODE_CAM2: fire = b_valid;
                MODE_AVG:  fire = a_have && b_have;
                default:   fire = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disp_valid <= 1'b0;
            drop       <= 1'b0;
            a_full     <= 1'b0;
            b_full     <= 1'b0;
        end else begin
            disp_valid <= fire;
            // at most one hold is ever full, so the other one is empty here.
            drop       <= avg_on && ((a_valid && a_full) || (b_valid && b_full));
            if (!avg_on || fire) begin
                a_full <= 1'b0;
                b_full <= 1'b0;
            end else begin
                if (a_valid) a_full <= 1'b1;
                if (b_valid) b_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (a_valid) begin
            a_hold_r <= a_r;
            a_hold_g <= a_g;
            a_hold_b <= a_b;
        end
        if (b_valid) begin
            b_hold_r <= b_r;
            b_hold_g <= b_g;
            b_hold_b <= b_b;
        end
        if (fire) begin
            case (mode)
                MODE_CAM1: begin
                    disp_r <= a_r;
                    disp_g <= a_g;
                    disp_b <= a_b;
                end
                MODE_CAM2: begin
                    disp_r <= b_r;
                    disp_g <= b_g;
                    disp_b <= b_b;
                end
                default: begin
                    disp_r <= avg2(a_eff_r, b_eff_r);
                    disp_g <= avg2(a_eff_g, b_eff_g);
                    disp_b <= avg2(a_eff_b, b_eff_b);
                end
            endcase
        end
    end

    a_no_pass_drop : assert property (
        @(posedge clk) disable iff (!rst_n)
        (mode == MODE_CAM1 || mode == MODE_CAM2) |=> !drop
    );

    // the register block must never hand over the reserved code.
    a_mode_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        mode == MODE_CAM1 || mode == MODE_CAM2 || mode == MODE_AVG
    );

endmodule

/* hw/view_regs.sv */
module view_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [view_regs_pkg::APB_AW-1:0] paddr,
    input  logic [view_regs_pkg::APB_DW-1:0] pwdata,
    input  logic                             disp_valid,
    input  logic                             drop,
    output logic [view_regs_pkg::APB_DW-1:0] prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic                             enable,
    output logic [pixel_pkg::MODE_W-1:0]     mode
);
    import pixel_pkg::*;
    import view_regs_pkg::*;

    logic              access;
    logic              wr;
    logic              addr_ok;
    logic              mode_ok;
    logic              ctrl_wr;
    logic              cnt_clr;
    logic [MODE_W-1:0] wr_mode;
    logic [CNT_W-1:0]  shown_cnt;
    logic [CNT_W-1:0]  drop_cnt;

    // ********************
    // apb decode
    // ********************
    assign pready  = 1'b1;
    assign access  = psel && penable;
    assign wr      = access && pwrite;
    assign wr_mode = pwdata[CTRL_MODE_LSB +: MODE_W];
    assign addr_ok = paddr inside {ADDR_CTRL, ADDR_SHOWN, ADDR_DROP};
    assign mode_ok = wr_mode inside {MODE_CAM1, MODE_CAM2, MODE_AVG};
    assign ctrl_wr = wr && (paddr == ADDR_CTRL) && mode_ok;
    assign cnt_clr = wr && (paddr == ADDR_SHOWN);

    assign pslverr = access && (!addr_ok || (pwrite && (paddr == ADDR_CTRL) && !mode_ok));

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                ADDR_CTRL: begin
                    prdata[CTRL_EN_BIT]              = enable;
                    prdata[CTRL_MODE_LSB +: MODE_W] = mode;
                end
                ADDR_SHOWN: prdata[CNT_W-1:0] = shown_cnt;
                ADDR_DROP:  prdata[CNT_W-1:0] = drop_cnt;
                default:    prdata = '0;
            endcase
        end
    end

    // ********************
    // control and counters
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable    <= 1'b0;
            mode      <= MODE_CAM1;
            shown_cnt <= '0;
            drop_cnt  <= '0;
        end else begin
            if (ctrl_wr) begin
                enable <= pwdata[CTRL_EN_BIT];
                mode   <= wr_mode;
            end
            // clear beats a count in the same cycle.
            if (cnt_clr) begin
                shown_cnt <= '0;
                drop_cnt  <= '0;
            end else begin
                if (disp_valid && shown_cnt != {CNT_W{1'b1}}) shown_cnt <= shown_cnt + 1'b1;
                if (drop && drop_cnt != {CNT_W{1'b1}}) drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    // an error only ends an access phase, and a rejected write leaves ctrl alone.
    a_err_access : assert property (
        @(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable) ##1 ($stable(enable) && $stable(mode))
    );

endmodule

/* hw/dual_cam_view.sv */
module dual_cam_view (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             cam1_vsync,
    input  logic                             cam1_href,
    input  logic                             cam1_byte_en,
    input  logic [7:0]                       cam1_data,

    input  logic                             cam2_vsync,
    input  logic                             cam2_href,
    input  logic                             cam2_byte_en,
    input  logic [7:0]                       cam2_data,

    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [view_regs_pkg::APB_AW-1:0] paddr,
    input  logic [view_regs_pkg::APB_DW-1:0] pwdata,
    output logic [view_regs_pkg::APB_DW-1:0] prdata,
    output logic                             pready,
    output logic                             pslverr,

    output logic                             disp_valid,
    output logic [pixel_pkg::CHAN_W-1:0]     disp_r,
    output logic [pixel_pkg::CHAN_W-1:0]     disp_g,
    output logic [pixel_pkg::CHAN_W-1:0]     disp_b
);
    import pixel_pkg::*;

    logic              cam1_valid, cam2_valid;
    logic [CHAN_W-1:0] cam1_r, cam1_g, cam1_b;
    logic [CHAN_W-1:0] cam2_r, cam2_g, cam2_b;
    logic              enable;
    logic [MODE_W-1:0] mode;
    logic              drop;

    // ********************
    // camera byte unpack
    // ********************
    cam_pixel_unpack u_cam1_unpack (
        .clk      (clk         ),
        .rst_n    (rst_n       ),
        .vsync    (cam1_vsync  ),
        .href     (cam1_href   ),
        .byte_en  (cam1_byte_en),
        .data     (cam1_data   ),
        .pix_valid(cam1_valid  ),
        .pix_r    (cam1_r      ),
        .pix_g    (cam1_g      ),
        .pix_b    (cam1_b      )
    );

    cam_pixel_unpack u_cam2_unpack (
        .clk      (clk         ),
        .rst_n    (rst_n       ),
        .vsync    (cam2_vsync  ),
        .href     (cam2_href   ),
        .byte_en  (cam2_byte_en),
        .data     (cam2_data   ),
        .pix_valid(cam2_valid  ),
        .pix_r    (cam2_r      ),
        .pix_g    (cam2_g      ),
        .pix_b    (cam2_b      )
    );

    // camera 1 feeds port a, camera 2 feeds port b.
    view_mixer u_mixer (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .enable    (enable    ),
        .mode      (mode      ),
        .a_valid   (cam1_valid),
        .a_r       (cam1_r    ),
        .a_g       (cam1_g    ),
        .a_b       (cam1_b    ),
        .b_valid   (cam2_valid),
        .b_r       (cam2_r    ),
        .b_g       (cam2_g    ),
        .b_b       (cam2_b    ),
        .disp_valid(disp_valid),
        .disp_r    (disp_r    ),
        .disp_g    (disp_g    ),
        .disp_b    (disp_b    ),
        .drop      (drop      )
    );

    view_regs u_regs (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .psel      (psel      ),
        .penable   (penable   ),
        .pwrite    (pwrite    ),
        .paddr     (paddr     ),
        .pwdata    (pwdata    ),
        .disp_valid(disp_valid),
        .drop      (drop      ),
        .prdata    (prdata    ),
        .pready    (pready    ),
        .pslverr   (pslverr   ),
        .enable    (enable    ),
        .mode      (mode      )
    );

endmodule

/* verification/tb_dual_cam_view.sv */
module tb_dual_cam_view;
    import pixel_pkg::*;
    import view_regs_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int CAM_CYCLES   = 600;
    localparam int AVG_CYCLES   = 1500;
    localparam int BUSY_CYCLES  = 200;
    localparam int OFF_CYCLES   = 300;
    localparam int APB_BUDGET   = 150;
    localparam int MARGIN       = 200;
    localparam int WATCHDOG_LIMIT = (RESET_CYCLES + 2 * CAM_CYCLES + AVG_CYCLES + BUSY_CYCLES
                                     + OFF_CYCLES + APB_BUDGET + MARGIN) * PERIOD;

    logic              clk;
    logic              rst_n;
    logic              cam1_vsync, cam1_href, cam1_byte_en;
    logic [7:0]        cam1_data;
    logic              cam2_vsync, cam2_href, cam2_byte_en;
    logic [7:0]        cam2_data;
    logic              psel, penable, pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready, pslverr;
    logic              disp_valid;
    logic [CHAN_W-1:0] disp_r, disp_g, disp_b;

    integer seed;
    int     pix_checked;

    // ********************
    // reference model state
    // ********************
    logic             m_phase[2];
    logic [7:0]       m_hi[2];
    logic             m_pv[2];
    logic [23:0]      m_pix[2];
    logic [23:0]      m_hold[2];
    logic             m_full[2];
    logic             m_dv, m_drop, m_en;
    logic [1:0]       m_mode;
    logic [23:0]      m_disp;
    logic [CNT_W-1:0] m_shown, m_dropped;

    dual_cam_view dual_cam_view_inst (
        .clk(clk), .rst_n(rst_n),
        .cam1_vsync(cam1_vsync), .cam1_href(cam1_href),
        .cam1_byte_en(cam1_byte_en), .cam1_data(cam1_data),
        .cam2_vsync(cam2_vsync), .cam2_href(cam2_href),
        .cam2_byte_en(cam2_byte_en), .cam2_data(cam2_data),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .disp_valid(disp_valid), .disp_r(disp_r), .disp_g(disp_g), .disp_b(disp_b)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_LIMIT);
        $display("Watchdog: simulation still running after %0d time units", WATCHDOG_LIMIT);
        $display("Done: errors found");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // rgb565 to rgb888 with zero padding.
    function automatic logic [23:0] expand565(input logic [15:0] w);
        return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
    endfunction

    function automatic logic [23:0] mean_rgb(input logic [23:0] x, input logic [23:0] y);
        logic [8:0]  s;
        logic [23:0] res;
        for (int i = 0; i < 3; i++) begin
            s = {1'b0, x[i*8 +: 8]} + {1'b0, y[i*8 +: 8]};
            res[i*8 +: 8] = s[8:1];
        end
        return res;
    endfunction

    function automatic logic [31:0] model_reg(input logic [APB_AW-1:0] addr);
        case (addr)
            ADDR_CTRL:  return {29'd0, m_mode, m_en};
            ADDR_SHOWN: return {16'd0, m_shown};
            ADDR_DROP:  return {16'd0, m_dropped};
            default:    return 32'd0;
        endcase
    endfunction

    task automatic model_reset();
        for (int c = 0; c < 2; c++) begin
            m_phase[c] = 1'b0;
            m_pv[c]    = 1'b0;
            m_full[c]  = 1'b0;
        end
        m_dv      = 1'b0;
        m_drop    = 1'b0;
        m_en      = 1'b0;
        m_mode    = MODE_CAM1;
        m_shown   = '0;
        m_dropped = '0;
    endtask

    task automatic unpack_step(input int c, input logic vs, input logic hr, input logic be,
                               input logic [7:0] d);
        logic take;
        take    = be && hr && !vs;
        m_pv[c] = take && m_phase[c];
        if (take && m_phase[c]) begin
            m_pix[c] = expand565({m_hi[c], d});
        end else if (take) begin
            m_hi[c] = d;
        end
        if (!hr || vs) begin
            m_phase[c] = 1'b0;
        end else if (take) begin
            m_phase[c] = !m_phase[c];
        end
    endtask

    // one clock of the whole pixel path; every stage reads the state before this edge.
    task automatic model_step();
        logic       wr;
        logic       avg;
        logic       fire;
        logic       n_en;
        logic [1:0] n_mode;
        wr     = psel && penable && pwrite;
        n_en   = m_en;
        n_mode = m_mode;
        if (wr && paddr == ADDR_CTRL && pwdata[2:1] != 2'd3) begin
            n_en   = pwdata[0];
            n_mode = pwdata[2:1];
        end
        if (wr && paddr == ADDR_SHOWN) begin
            m_shown   = '0;
            m_dropped = '0;
        end else begin
            if (m_dv && m_shown != '1) m_shown++;
            if (m_drop && m_dropped != '1) m_dropped++;
        end
        avg = m_en && (m_mode == MODE_AVG);
        case (m_mode)
            MODE_CAM1: fire = m_pv[0];
            MODE_CAM2: fire = m_pv[1];
            MODE_AVG:  fire = (m_pv[0] || m_full[0]) && (m_pv[1] || m_full[1]);
            default:   fire = 1'b0;
        endcase
        fire   = fire && m_en;
        m_drop = avg && ((m_pv[0] && m_full[0]) || (m_pv[1] && m_full[1]));
        for (int c = 0; c < 2; c++) begin
            if (m_pv[c]) m_hold[c] = m_pix[c];
        end
        if (fire) begin
            if (m_mode == MODE_CAM1) m_disp = m_pix[0];
            else if (m_mode == MODE_CAM2) m_disp = m_pix[1];
            else m_disp = mean_rgb(m_hold[0], m_hold[1]);
        end
        m_dv = fire;
        for (int c = 0; c < 2; c++) begin
            if (!avg || fire) m_full[c] = 1'b0;
            else if (m_pv[c]) m_full[c] = 1'b1;
        end
        unpack_step(0, cam1_vsync, cam1_href, cam1_byte_en, cam1_data);
        unpack_step(1, cam2_vsync, cam2_href, cam2_byte_en, cam2_data);
        m_en   = n_en;
        m_mode = n_mode;
    endtask

    always @(posedge clk) begin
        if (!rst_n) model_reset();
        else model_step();
    end

    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            check_value("disp_valid", 32'(disp_valid), 32'(m_dv));
            if (m_dv) begin
                check_value("disp_r", 32'(disp_r), 32'(m_disp[23:16]));
                check_value("disp_g", 32'(disp_g), 32'(m_disp[15:8]));
                check_value("disp_b", 32'(disp_b), 32'(m_disp[7:0]));
                pix_checked++;
            end
        end
    end

    // ********************
    // apb and camera drivers
    // ********************
    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_value("pready", 32'(pready), 32'd1);
        check_value("pslverr", 32'(pslverr), 32'(exp_err));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, input logic exp_err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_value("pready", 32'(pready), 32'd1);
        check_value("pslverr", 32'(pslverr), 32'(exp_err));
        if (!exp_err) check_value("prdata", prdata, model_reg(addr));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic drive_cameras(input int cycles, input logic cam1_on, input logic cam2_on);
        logic [31:0] r1;
        logic [31:0] r2;
        repeat (cycles) begin
            r1 = next_random();
            r2 = next_random();
            @(posedge clk);
            // href falls about one cycle in 32 and vsync pulses rarely.
            cam1_href    <= cam1_on && (r1[4:0] != 5'd0);
            cam1_vsync   <= (r1[15:9] == 7'd0);
            cam1_byte_en <= cam1_on && (r1[6:5] != 2'd0);
            cam1_data    <= r1[31:24];
            cam2_href    <= cam2_on && (r2[4:0] != 5'd0);
            cam2_vsync   <= (r2[15:9] == 7'd0);
            cam2_byte_en <= cam2_on && (r2[6:5] != 2'd0);
            cam2_data    <= r2[31:24];
        end
    endtask

    task automatic idle_cameras();
        @(posedge clk);
        cam1_href    <= 1'b0;
        cam1_vsync   <= 1'b0;
        cam1_byte_en <= 1'b0;
        cam2_href    <= 1'b0;
        cam2_vsync   <= 1'b0;
        cam2_byte_en <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic await_display(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (!disp_valid && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!disp_valid) begin
            $display("Error: no display pixel appeared within %0d cycles", max_cycles);
            $display("Done: errors found");
            $fatal(1, "display timeout");
        end
    endtask

    // ********************
    // test sequence
    // ********************
    initial begin
        seed = 48763;
        pix_checked = 0;
        rst_n = 1'b0;
        {cam1_vsync, cam1_href, cam1_byte_en, cam1_data} = '0;
        {cam2_vsync, cam2_href, cam2_byte_en, cam2_data} = '0;
        {psel, penable, pwrite} = '0;
        paddr  = '0;
        pwdata = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // reset values and the first enable with camera 1.
        apb_read(ADDR_CTRL, 1'b0);
        apb_read(ADDR_SHOWN, 1'b0);
        apb_read(ADDR_DROP, 1'b0);
        apb_write(ADDR_CTRL, 32'h1, 1'b0);
        apb_read(ADDR_CTRL, 1'b0);
        check_value("ctrl readback", model_reg(ADDR_CTRL), 32'h1);

        drive_cameras(CAM_CYCLES, 1'b1, 1'b1);
        idle_cameras();
        apb_read(ADDR_SHOWN, 1'b0);
        apb_read(ADDR_DROP, 1'b0);

        // camera 2 after a lone byte that href cuts off.
        apb_write(ADDR_CTRL, {29'd0, MODE_CAM2, 1'b1}, 1'b0);
        @(posedge clk);
        cam2_href    <= 1'b1;
        cam2_byte_en <= 1'b1;
        cam2_data    <= 8'hA5;
        @(posedge clk);
        cam2_href    <= 1'b0;
        cam2_byte_en <= 1'b0;
        @(posedge clk);
        cam2_href    <= 1'b1;
        cam2_byte_en <= 1'b1;
        cam2_data    <= 8'h12;
        @(posedge clk);
        cam2_data    <= 8'h34;
        @(posedge clk);
        cam2_byte_en <= 1'b0;
        await_display(8);
        check_value("disp_r", 32'(disp_r), 32'(expand565(16'h1234) >> 16));
        check_value("disp_g", 32'(disp_g), 32'(expand565(16'h1234) >> 8) & 32'hFF);
        check_value("disp_b", 32'(disp_b), 32'(expand565(16'h1234)) & 32'hFF);
        drive_cameras(CAM_CYCLES, 1'b1, 1'b1);
        idle_cameras();
        apb_read(ADDR_SHOWN, 1'b0);
        apb_read(ADDR_DROP, 1'b0);

        apb_write(ADDR_CTRL, {29'd0, MODE_AVG, 1'b1}, 1'b0);
        drive_cameras(AVG_CYCLES, 1'b1, 1'b1);
        idle_cameras();
        apb_read(ADDR_SHOWN, 1'b0);
        apb_read(ADDR_DROP, 1'b0);

        // clear lands in the middle of live traffic.
        fork
            drive_cameras(BUSY_CYCLES, 1'b1, 1'b1);
            begin
                repeat (BUSY_CYCLES / 2) @(posedge clk);
                apb_write(ADDR_SHOWN, 32'd0, 1'b0);
            end
        join
        idle_cameras();
        apb_read(ADDR_SHOWN, 1'b0);
        apb_read(ADDR_DROP, 1'b0);
        apb_write(ADDR_SHOWN, 32'd0, 1'b0);
        apb_write(ADDR_CTRL, {29'd0, MODE_AVG, 1'b0}, 1'b0);
        drive_cameras(OFF_CYCLES, 1'b1, 1'b1);
        idle_cameras();
        check_value("shown count while disabled", 32'(m_shown), 32'd0);
        apb_read(ADDR_SHOWN, 1'b0);
        apb_read(ADDR_DROP, 1'b0);

        // unmapped addresses and the reserved mode.
        apb_read(4'hC, 1'b1);
        apb_write(4'h2, 32'h5, 1'b1);
        apb_write(ADDR_CTRL, 32'h7, 1'b1);
        apb_read(ADDR_CTRL, 1'b0);
        check_value("ctrl after rejected writes", model_reg(ADDR_CTRL), {29'd0, MODE_AVG, 1'b0});

        repeat (4) @(posedge clk);
        if (pix_checked > 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Error: no display pixels were compared");
            $display("Done: errors found");
            $fatal(1, "empty run");
        end
    end

endmodule

/* project.f */
hw/pixel_pkg.sv
hw/view_regs_pkg.sv
hw/cam_pixel_unpack.sv
hw/view_mixer.sv
hw/view_regs.sv
hw/dual_cam_view.sv
verification/tb_dual_cam_view.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dual camera view testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module tb_dual_cam_view \
    -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_dual_cam_view" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
